// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// Datapath and register file geometry
	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam int reg_count = 1 << reg_addr_w;

	// Word-addressed data memory
	localparam int dmem_words = 256;
	localparam int dmem_addr_w = $clog2(dmem_words);

	// Opcodes
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j = 6'h02;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_bne = 6'h05;
	localparam logic [5:0] op_addi = 6'h08;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_sw = 6'h2b;
	localparam logic [5:0] op_hlt = 6'h3f;

	// Funct codes for R-type
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_t;

	// Operand source chosen by the forwarding logic
	typedef enum logic [1:0] {
		fwd_rf,
		fwd_mem,
		fwd_wb
	} fwd_sel_t;

endpackage

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     halted,
	input  logic                     stall,
	input  logic                     jump,
	input  logic [cpu_pkg::xlen-1:0] jump_target,
	input  logic                     branch_taken,
	input  logic [cpu_pkg::xlen-1:0] branch_target,
	input  logic [cpu_pkg::xlen-1:0] imem_data,
	output logic [cpu_pkg::xlen-1:0] pc,
	output logic [cpu_pkg::xlen-1:0] if_pc,
	output logic [cpu_pkg::xlen-1:0] if_inst,
	output logic                     if_valid
);
	import cpu_pkg::*;

	logic [xlen-1:0] pc_next;

	// Branch from EX is older than a jump in ID, so it wins
	always_comb begin
		if (branch_taken)
			pc_next = branch_target;
		else if (jump)
			pc_next = jump_target;
		else if (stall)
			pc_next = pc;
		else
			pc_next = pc + xlen'(1);
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (!halted)
			pc <= pc_next;
	end

	// IF/ID valid bit
	always_ff @(posedge clk) begin
		if (rst) begin
			if_valid <= 1'b0;
		end else if (!halted) begin
			if (branch_taken || jump)
				if_valid <= 1'b0;
			else if (!stall)
				if_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!halted && !stall) begin
			if_pc <= pc;
			if_inst <= imem_data;
		end
	end

	assert property (@(posedge clk) disable iff (rst) halted |=> $stable(pc))
		else $error("fetch_stage: PC changed while halted");

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           halted,
	input  logic [cpu_pkg::xlen-1:0]       if_pc,
	input  logic [cpu_pkg::xlen-1:0]       if_inst,
	input  logic                           if_valid,
	input  logic                           branch_taken,
	input  logic                           wb_valid,
	input  logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
	input  logic [cpu_pkg::xlen-1:0]       wb_data,
	output logic                           stall,
	output logic                           jump,
	output logic [cpu_pkg::xlen-1:0]       jump_target,
	output logic                           ex_valid,
	output logic [cpu_pkg::xlen-1:0]       ex_pc,
	output cpu_pkg::alu_op_t               ex_alu_op,
	output logic [cpu_pkg::reg_addr_w-1:0] ex_rs1,
	output logic [cpu_pkg::reg_addr_w-1:0] ex_rs2,
	output logic [cpu_pkg::reg_addr_w-1:0] ex_rd,
	output logic [cpu_pkg::xlen-1:0]       ex_rs1_val,
	output logic [cpu_pkg::xlen-1:0]       ex_rs2_val,
	output logic [cpu_pkg::xlen-1:0]       ex_imm,
	output logic                           ex_use_imm,
	output logic                           ex_regwrite,
	output logic                           ex_memread,
	output logic                           ex_memwrite,
	output logic                           ex_is_beq,
	output logic                           ex_is_bne,
	output logic                           ex_is_hlt
);
	import cpu_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [reg_addr_w-1:0] rs;
	logic [reg_addr_w-1:0] rt;
	logic [reg_addr_w-1:0] rd_field;
	logic [reg_addr_w-1:0] dest;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] pc_plus1;
	alu_op_t alu_op;
	logic use_imm;
	logic regwrite;
	logic memread;
	logic memwrite;
	logic is_beq;
	logic is_bne;
	logic is_hlt;
	logic is_j;
	logic uses_rs1;
	logic uses_rs2;
	logic bubble;
	logic [xlen-1:0] rs1_val;
	logic [xlen-1:0] rs2_val;
	logic [xlen-1:0] regs [reg_count];

	assign opcode = if_inst[31:26];
	assign rs = if_inst[25:21];
	assign rt = if_inst[20:16];
	assign rd_field = if_inst[15:11];
	assign funct = if_inst[5:0];
	assign imm = {{(xlen-16){if_inst[15]}}, if_inst[15:0]};

	always_comb begin
		alu_op = alu_add;
		dest = rt;
		use_imm = 1'b0;
		regwrite = 1'b0;
		memread = 1'b0;
		memwrite = 1'b0;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_hlt = 1'b0;
		is_j = 1'b0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (opcode)
			op_rtype: begin
				dest = rd_field;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				regwrite = 1'b1;
				case (funct)
					fn_add: alu_op = alu_add;
					fn_sub: alu_op = alu_sub;
					fn_and: alu_op = alu_and;
					fn_or: alu_op = alu_or;
					fn_slt: alu_op = alu_slt;
					default: regwrite = 1'b0;
				endcase
			end
			op_addi, op_lw: begin
				use_imm = 1'b1;
				uses_rs1 = 1'b1;
				regwrite = 1'b1;
				memread = (opcode == op_lw);
			end
			op_sw: begin
				use_imm = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				memwrite = 1'b1;
			end
			op_beq, op_bne: begin
				alu_op = alu_sub;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				is_beq = (opcode == op_beq);
				is_bne = (opcode == op_bne);
			end
			op_j: is_j = 1'b1;
			op_hlt: is_hlt = 1'b1;
			default: ;
		endcase
	end

	// Register file with r0 at zero and a WB write bypassed to the read
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (wb_valid && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	assign rs1_val = (rs == '0) ? '0 : (wb_valid && wb_rd == rs) ? wb_data : regs[rs];
	assign rs2_val = (rt == '0) ? '0 : (wb_valid && wb_rd == rt) ? wb_data : regs[rt];

	// Load in EX feeding this instruction
	assign stall = if_valid && ex_valid && ex_memread && ex_rd != '0 &&
		((uses_rs1 && rs == ex_rd) || (uses_rs2 && rt == ex_rd));

	assign pc_plus1 = if_pc + xlen'(1);
	assign jump = if_valid && is_j;
	assign jump_target = {pc_plus1[xlen-1:26], if_inst[25:0]};

	assign bubble = !if_valid || stall || branch_taken;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
			ex_regwrite <= 1'b0;
			ex_memread <= 1'b0;
			ex_memwrite <= 1'b0;
			ex_is_beq <= 1'b0;
			ex_is_bne <= 1'b0;
			ex_is_hlt <= 1'b0;
		end else if (!halted) begin
			ex_valid <= !bubble;
			ex_regwrite <= !bubble && regwrite;
			ex_memread <= !bubble && memread;
			ex_memwrite <= !bubble && memwrite;
			ex_is_beq <= !bubble && is_beq;
			ex_is_bne <= !bubble && is_bne;
			ex_is_hlt <= !bubble && is_hlt;
		end
	end

	always_ff @(posedge clk) begin
		if (!halted) begin
			ex_pc <= if_pc;
			ex_alu_op <= alu_op;
			ex_rs1 <= rs;
			ex_rs2 <= rt;
			ex_rd <= dest;
			ex_rs1_val <= rs1_val;
			ex_rs2_val <= rs2_val;
			ex_imm <= imm;
			ex_use_imm <= use_imm;
		end
	end

	assert property (@(posedge clk) disable iff (rst) !(stall && branch_taken))
		else $error("decode_stage: load-use stall during a branch flush");

endmodule

`default_nettype wire

// File: hw/forward_unit.sv
`timescale 1ns/10ps
`default_nettype none

module forward_unit (
	input  logic [cpu_pkg::reg_addr_w-1:0] ex_rs1,
	input  logic [cpu_pkg::reg_addr_w-1:0] ex_rs2,
	input  logic                           ex_use_imm,
	input  logic [cpu_pkg::reg_addr_w-1:0] mem_rd,
	input  logic                           mem_regwrite,
	input  logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
	input  logic                           wb_regwrite,
	output cpu_pkg::fwd_sel_t              fwd_a,
	output cpu_pkg::fwd_sel_t              fwd_b,
	output cpu_pkg::fwd_sel_t              fwd_store
);
	import cpu_pkg::*;

	// Newest producer first and r0 never forwards
	function automatic fwd_sel_t source_for(input logic [reg_addr_w-1:0] src);
		if (mem_regwrite && mem_rd != '0 && mem_rd == src)
			return fwd_mem;
		else if (wb_regwrite && wb_rd != '0 && wb_rd == src)
			return fwd_wb;
		else
			return fwd_rf;
	endfunction

	always_comb begin
		fwd_a = source_for(ex_rs1);
		fwd_store = source_for(ex_rs2);
		// Immediate takes the B slot in execute
		if (ex_use_imm)
			fwd_b = fwd_rf;
		else
			fwd_b = fwd_store;
	end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           halted,
	input  logic                           ex_valid,
	input  logic [cpu_pkg::xlen-1:0]       ex_pc,
	input  cpu_pkg::alu_op_t               ex_alu_op,
	input  logic [cpu_pkg::reg_addr_w-1:0] ex_rd,
	input  logic [cpu_pkg::xlen-1:0]       ex_rs1_val,
	input  logic [cpu_pkg::xlen-1:0]       ex_rs2_val,
	input  logic [cpu_pkg::xlen-1:0]       ex_imm,
	input  logic                           ex_use_imm,
	input  logic                           ex_regwrite,
	input  logic                           ex_memread,
	input  logic                           ex_memwrite,
	input  logic                           ex_is_beq,
	input  logic                           ex_is_bne,
	input  logic                           ex_is_hlt,
	input  cpu_pkg::fwd_sel_t              fwd_a,
	input  cpu_pkg::fwd_sel_t              fwd_b,
	input  cpu_pkg::fwd_sel_t              fwd_store,
	input  logic [cpu_pkg::xlen-1:0]       wb_data,
	output logic                           branch_taken,
	output logic [cpu_pkg::xlen-1:0]       branch_target,
	output logic                           mem_valid,
	output logic [cpu_pkg::reg_addr_w-1:0] mem_rd,
	output logic                           mem_regwrite,
	output logic                           mem_memread,
	output logic                           mem_memwrite,
	output logic [cpu_pkg::xlen-1:0]       mem_result,
	output logic [cpu_pkg::xlen-1:0]       mem_store_data,
	output logic                           mem_is_hlt
);
	import cpu_pkg::*;

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] rs2_fwd;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] store_data;
	logic [xlen-1:0] alu_result;

	always_comb begin
		case (fwd_a)
			fwd_mem: op_a = mem_result;
			fwd_wb: op_a = wb_data;
			default: op_a = ex_rs1_val;
		endcase
		case (fwd_b)
			fwd_mem: rs2_fwd = mem_result;
			fwd_wb: rs2_fwd = wb_data;
			default: rs2_fwd = ex_rs2_val;
		endcase
		case (fwd_store)
			fwd_mem: store_data = mem_result;
			fwd_wb: store_data = wb_data;
			default: store_data = ex_rs2_val;
		endcase
	end

	assign op_b = ex_use_imm ? ex_imm : rs2_fwd;

	always_comb begin
		case (ex_alu_op)
			alu_sub: alu_result = op_a - op_b;
			alu_and: alu_result = op_a & op_b;
			alu_or: alu_result = op_a | op_b;
			alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default: alu_result = op_a + op_b;
		endcase
	end

	// Offset in words from the branch PC plus one
	assign branch_target = ex_pc + xlen'(1) + ex_imm;
	assign branch_taken = ex_valid && !halted &&
		((ex_is_beq && op_a == rs2_fwd) || (ex_is_bne && op_a != rs2_fwd));

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_valid <= 1'b0;
			mem_regwrite <= 1'b0;
			mem_memread <= 1'b0;
			mem_memwrite <= 1'b0;
			mem_is_hlt <= 1'b0;
		end else if (!halted) begin
			mem_valid <= ex_valid;
			mem_regwrite <= ex_valid && ex_regwrite;
			mem_memread <= ex_valid && ex_memread;
			mem_memwrite <= ex_valid && ex_memwrite;
			mem_is_hlt <= ex_valid && ex_is_hlt;
		end
	end

	always_ff @(posedge clk) begin
		if (!halted) begin
			mem_rd <= ex_rd;
			mem_result <= alu_result;
			mem_store_data <= store_data;
		end
	end

endmodule

`default_nettype wire

// File: hw/memory_stage.sv
`timescale 1ns/10ps
`default_nettype none

module memory_stage (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           mem_valid,
	input  logic [cpu_pkg::reg_addr_w-1:0] mem_rd,
	input  logic                           mem_regwrite,
	input  logic                           mem_memread,
	input  logic                           mem_memwrite,
	input  logic [cpu_pkg::xlen-1:0]       mem_result,
	input  logic [cpu_pkg::xlen-1:0]       mem_store_data,
	input  logic                           mem_is_hlt,
	output logic                           wb_valid,
	output logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
	output logic [cpu_pkg::xlen-1:0]       wb_data,
	output logic                           halted
);
	import cpu_pkg::*;

	logic [xlen-1:0] dmem [dmem_words];
	logic [dmem_addr_w-1:0] word_addr;
	logic [xlen-1:0] load_data;
	logic wb_is_hlt;
	logic freeze;

	// Byte address to word index
	assign word_addr = mem_result[dmem_addr_w+1:2];
	assign load_data = dmem[word_addr];

	// Once hlt sits in WB nothing younger may commit
	assign freeze = halted || wb_is_hlt;

	always_ff @(posedge clk) begin
		if (mem_valid && mem_memwrite && !freeze)
			dmem[word_addr] <= mem_store_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			wb_is_hlt <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (!freeze) begin
				wb_valid <= mem_valid && mem_regwrite && mem_rd != '0;
				wb_is_hlt <= mem_valid && mem_is_hlt;
			end
			if (wb_is_hlt)
				halted <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			wb_rd <= mem_rd;
			wb_data <= mem_memread ? load_data : mem_result;
		end
	end

	assert property (@(posedge clk) disable iff (rst) wb_valid |-> wb_rd != '0)
		else $error("memory_stage: write-back addressed to r0");

endmodule

`default_nettype wire

// File: hw/pl_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module pl_cpu (
	input  logic                           input_clk,
	input  logic                           rst,
	input  logic [cpu_pkg::xlen-1:0]       imem_data,
	output logic [cpu_pkg::xlen-1:0]       PC,
	output logic [cpu_pkg::xlen-1:0]       cycles_consumed,
	output logic                           halted,
	output logic                           wb_valid,
	output logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
	output logic [cpu_pkg::xlen-1:0]       wb_data
);
	import cpu_pkg::*;

	logic [xlen-1:0] if_pc;
	logic [xlen-1:0] if_inst;
	logic if_valid;
	logic stall;
	logic jump;
	logic [xlen-1:0] jump_target;
	logic branch_taken;
	logic [xlen-1:0] branch_target;

	logic ex_valid;
	logic [xlen-1:0] ex_pc;
	alu_op_t ex_alu_op;
	logic [reg_addr_w-1:0] ex_rs1;
	logic [reg_addr_w-1:0] ex_rs2;
	logic [reg_addr_w-1:0] ex_rd;
	logic [xlen-1:0] ex_rs1_val;
	logic [xlen-1:0] ex_rs2_val;
	logic [xlen-1:0] ex_imm;
	logic ex_use_imm;
	logic ex_regwrite;
	logic ex_memread;
	logic ex_memwrite;
	logic ex_is_beq;
	logic ex_is_bne;
	logic ex_is_hlt;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;
	fwd_sel_t fwd_store;

	logic mem_valid;
	logic [reg_addr_w-1:0] mem_rd;
	logic mem_regwrite;
	logic mem_memread;
	logic mem_memwrite;
	logic [xlen-1:0] mem_result;
	logic [xlen-1:0] mem_store_data;
	logic mem_is_hlt;

	// Edges since reset until the machine halts
	always_ff @(posedge input_clk) begin
		if (rst)
			cycles_consumed <= '0;
		else if (!halted)
			cycles_consumed <= cycles_consumed + xlen'(1);
	end

	fetch_stage fetch_stage_inst (
		.clk(input_clk), .rst(rst), .halted(halted), .stall(stall),
		.jump(jump), .jump_target(jump_target),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.imem_data(imem_data), .pc(PC),
		.if_pc(if_pc), .if_inst(if_inst), .if_valid(if_valid)
	);

	decode_stage decode_stage_inst (
		.clk(input_clk), .rst(rst), .halted(halted),
		.if_pc(if_pc), .if_inst(if_inst), .if_valid(if_valid),
		.branch_taken(branch_taken),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
		.stall(stall), .jump(jump), .jump_target(jump_target),
		.ex_valid(ex_valid), .ex_pc(ex_pc), .ex_alu_op(ex_alu_op),
		.ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
		.ex_rs1_val(ex_rs1_val), .ex_rs2_val(ex_rs2_val),
		.ex_imm(ex_imm), .ex_use_imm(ex_use_imm), .ex_regwrite(ex_regwrite),
		.ex_memread(ex_memread), .ex_memwrite(ex_memwrite),
		.ex_is_beq(ex_is_beq), .ex_is_bne(ex_is_bne), .ex_is_hlt(ex_is_hlt)
	);

	forward_unit forward_unit_inst (
		.ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_use_imm(ex_use_imm),
		.mem_rd(mem_rd), .mem_regwrite(mem_regwrite),
		.wb_rd(wb_rd), .wb_regwrite(wb_valid),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_store(fwd_store)
	);

	execute_stage execute_stage_inst (
		.clk(input_clk), .rst(rst), .halted(halted),
		.ex_valid(ex_valid), .ex_pc(ex_pc), .ex_alu_op(ex_alu_op), .ex_rd(ex_rd),
		.ex_rs1_val(ex_rs1_val), .ex_rs2_val(ex_rs2_val),
		.ex_imm(ex_imm), .ex_use_imm(ex_use_imm), .ex_regwrite(ex_regwrite),
		.ex_memread(ex_memread), .ex_memwrite(ex_memwrite),
		.ex_is_beq(ex_is_beq), .ex_is_bne(ex_is_bne), .ex_is_hlt(ex_is_hlt),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_store(fwd_store), .wb_data(wb_data),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.mem_valid(mem_valid), .mem_rd(mem_rd), .mem_regwrite(mem_regwrite),
		.mem_memread(mem_memread), .mem_memwrite(mem_memwrite),
		.mem_result(mem_result), .mem_store_data(mem_store_data),
		.mem_is_hlt(mem_is_hlt)
	);

	memory_stage memory_stage_inst (
		.clk(input_clk), .rst(rst),
		.mem_valid(mem_valid), .mem_rd(mem_rd), .mem_regwrite(mem_regwrite),
		.mem_memread(mem_memread), .mem_memwrite(mem_memwrite),
		.mem_result(mem_result), .mem_store_data(mem_store_data),
		.mem_is_hlt(mem_is_hlt),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .halted(halted)
	);

endmodule

`default_nettype wire

// File: test/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic logic [31:0] rtype_word(input logic [5:0] funct, input int rd, input int rs,
		input int rt);
	return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
endfunction

// Also used for lw, sw and the branches, where rt is the data or compare register
function automatic logic [31:0] itype_word(input logic [5:0] op, input int rt, input int rs,
		input int imm);
	return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic logic [31:0] jump_word(input int target);
	return {op_j, 26'(target)};
endfunction

function automatic logic [31:0] halt_word();
	return {op_hlt, 26'd0};
endfunction

function automatic logic [31:0] next_random();
	logic [31:0] x;
	x = rng_state;
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	rng_state = x;
	return x;
endfunction

// Each result feeds the next instruction
function automatic void alu_chain_program();
	prog.delete();
	prog.push_back(itype_word(op_addi, 1, 0, 12));
	prog.push_back(itype_word(op_addi, 2, 1, -5));
	prog.push_back(rtype_word(fn_add, 3, 1, 2));
	prog.push_back(rtype_word(fn_sub, 4, 3, 1));
	prog.push_back(rtype_word(fn_and, 5, 4, 3));
	prog.push_back(rtype_word(fn_or, 6, 5, 4));
	prog.push_back(rtype_word(fn_slt, 7, 6, 5));
	prog.push_back(rtype_word(fn_slt, 8, 0, 7));
	prog.push_back(rtype_word(fn_add, 0, 7, 7));
	prog.push_back(rtype_word(fn_add, 9, 0, 6));
	prog.push_back(itype_word(op_addi, 10, 9, -100));
	prog.push_back(rtype_word(fn_slt, 11, 10, 0));
	prog.push_back(halt_word());
endfunction

function automatic void load_store_program();
	prog.delete();
	prog.push_back(itype_word(op_addi, 1, 0, 'h55));
	prog.push_back(itype_word(op_addi, 2, 0, 8));
	prog.push_back(itype_word(op_sw, 1, 2, 0));
	prog.push_back(itype_word(op_lw, 3, 2, 0));
	prog.push_back(rtype_word(fn_add, 4, 3, 3));
	prog.push_back(itype_word(op_addi, 5, 0, -7));
	prog.push_back(itype_word(op_sw, 5, 2, 4));
	prog.push_back(itype_word(op_lw, 6, 2, 4));
	// Store data comes straight from the load before it
	prog.push_back(itype_word(op_sw, 6, 2, 12));
	prog.push_back(itype_word(op_lw, 7, 2, 12));
	prog.push_back(rtype_word(fn_sub, 8, 7, 4));
	prog.push_back(halt_word());
endfunction

// r10, r11 and r12 sit in branch shadows and must never be written
function automatic void branch_program();
	prog.delete();
	prog.push_back(itype_word(op_addi, 1, 0, 3));
	prog.push_back(itype_word(op_addi, 2, 0, 3));
	prog.push_back(itype_word(op_beq, 2, 1, 2));
	prog.push_back(itype_word(op_addi, 10, 0, 1));
	prog.push_back(itype_word(op_addi, 11, 0, 1));
	prog.push_back(itype_word(op_beq, 0, 1, 2));
	prog.push_back(itype_word(op_addi, 3, 0, 5));
	prog.push_back(itype_word(op_bne, 1, 3, 1));
	prog.push_back(itype_word(op_addi, 12, 0, 1));
	prog.push_back(itype_word(op_addi, 4, 0, 0));
	prog.push_back(itype_word(op_addi, 4, 4, 1));
	prog.push_back(itype_word(op_bne, 1, 4, -2));
	prog.push_back(itype_word(op_addi, 5, 4, 10));
	prog.push_back(halt_word());
endfunction

function automatic void halt_timing_program();
	prog.delete();
	prog.push_back(itype_word(op_addi, 1, 0, 1));
	prog.push_back(itype_word(op_addi, 2, 0, 2));
	prog.push_back(itype_word(op_addi, 3, 0, 3));
	prog.push_back(itype_word(op_addi, 4, 0, 4));
	prog.push_back(rtype_word(fn_add, 5, 1, 2));
	prog.push_back(rtype_word(fn_or, 6, 3, 4));
	prog.push_back(halt_word());
endfunction

function automatic void jump_program();
	prog.delete();
	prog.push_back(itype_word(op_addi, 1, 0, 1));
	prog.push_back(jump_word(3));
	prog.push_back(itype_word(op_addi, 2, 0, 99));
	prog.push_back(itype_word(op_addi, 3, 1, 2));
	prog.push_back(halt_word());
endfunction

// Random ALU work on r0..r7, then every register goes through memory and back
function automatic void random_program();
	logic [31:0] r;
	prog.delete();
	for (int i = 0; i < 40; i++) begin
		r = next_random();
		case (r[11:9])
			3'd0: prog.push_back(rtype_word(fn_add, int'(r[2:0]), int'(r[5:3]), int'(r[8:6])));
			3'd1: prog.push_back(rtype_word(fn_sub, int'(r[2:0]), int'(r[5:3]), int'(r[8:6])));
			3'd2: prog.push_back(rtype_word(fn_and, int'(r[2:0]), int'(r[5:3]), int'(r[8:6])));
			3'd3: prog.push_back(rtype_word(fn_or, int'(r[2:0]), int'(r[5:3]), int'(r[8:6])));
			3'd4: prog.push_back(rtype_word(fn_slt, int'(r[2:0]), int'(r[5:3]), int'(r[8:6])));
			default: prog.push_back(itype_word(op_addi, int'(r[2:0]), int'(r[5:3]),
				int'(r[31:16])));
		endcase
	end
	for (int x = 1; x < 8; x++)
		prog.push_back(itype_word(op_sw, x, 0, 64 + 4 * x));
	for (int x = 1; x < 8; x++)
		prog.push_back(itype_word(op_lw, x, 0, 64 + 4 * x));
	prog.push_back(halt_word());
endfunction

`endif

// File: test/tb_pl_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pl_cpu;
	import cpu_pkg::*;

	localparam int half_period = 50;
	localparam int reset_cycles = 8;
	localparam int test_count = 6;
	localparam int test_budget = 300;
	localparam int freeze_cycles = 10;
	localparam int cycle_limit =
		test_count * (test_budget + reset_cycles + freeze_cycles + 1);

	logic input_clk;
	logic rst;
	logic [xlen-1:0] imem_data;
	logic [xlen-1:0] PC;
	logic [xlen-1:0] cycles_consumed;
	logic halted;
	logic wb_valid;
	logic [reg_addr_w-1:0] wb_rd;
	logic [xlen-1:0] wb_data;

	logic [31:0] imem [256];
	logic [31:0] prog [$];
	logic [4:0] exp_rd [$];
	logic [31:0] exp_data [$];
	int expected_cycles;
	int error_count;
	int tests_passed;
	int tests_failed;
	int cycle_count;
	logic monitor_on;
	logic [31:0] written_mask;
	logic [31:0] rng_state;

	`include "tb_programs.svh"

	pl_cpu pl_cpu_inst (
		.input_clk(input_clk), .rst(rst), .imem_data(imem_data), .PC(PC),
		.cycles_consumed(cycles_consumed), .halted(halted),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	// Instruction memory answers in the same cycle
	assign imem_data = imem[PC[7:0]];

	always #(half_period) input_clk = ~input_clk;

	always @(posedge input_clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s = 0x%08h, expected 0x%08h",
				$time, name, actual, expected);
			error_count++;
		end
	endtask

	// Write-backs are registered, so they are settled by the falling edge
	always @(negedge input_clk) begin
		if (monitor_on && !rst && wb_valid) begin
			written_mask[wb_rd] = 1'b1;
			if (exp_rd.size() == 0) begin
				$display("Write-back of 0x%08h to r%0d at %0t was not expected",
					wb_data, wb_rd, $time);
				error_count++;
			end else begin
				check_value("wb_rd", 32'(wb_rd), 32'(exp_rd.pop_front()));
				check_value("wb_data", wb_data, exp_data.pop_front());
			end
		end
	end

	// Unused words hold addi r0 with the address as its immediate
	task automatic fill_imem();
		for (int a = 0; a < 256; a++)
			imem[a] = itype_word(op_addi, 0, 0, a);
		foreach (prog[i])
			imem[i] = prog[i];
	endtask

	// Architectural model that also counts the cycles the pipeline should take
	task automatic model_program();
		logic [31:0] regs [32];
		logic [31:0] dmem [256];
		logic [31:0] pc;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] load_rd;
		logic prev_load;
		logic wr_en;
		logic [4:0] wr_rd;
		logic [31:0] wr_val;
		logic done;
		int steps;
		exp_rd.delete();
		exp_data.delete();
		foreach (regs[i])
			regs[i] = '0;
		foreach (dmem[i])
			dmem[i] = '0;
		pc = '0;
		prev_load = 1'b0;
		load_rd = '0;
		done = 1'b0;
		steps = 0;
		expected_cycles = 4;
		while (!done && steps < 500) begin
			inst = imem[pc[7:0]];
			op = inst[31:26];
			rs = inst[25:21];
			rt = inst[20:16];
			a = regs[rs];
			b = regs[rt];
			imm = {{16{inst[15]}}, inst[15:0]};
			addr = a + imm;
			if (prev_load && ((op inside {op_rtype, op_addi, op_lw, op_sw, op_beq, op_bne} &&
					rs == load_rd) || (op inside {op_rtype, op_sw, op_beq, op_bne} &&
					rt == load_rd)))
				expected_cycles++;
			prev_load = (op == op_lw) && (rt != 5'd0);
			load_rd = rt;
			expected_cycles++;
			steps++;
			pc = pc + 32'd1;
			wr_en = 1'b0;
			wr_rd = rt;
			wr_val = '0;
			case (op)
				op_rtype: begin
					wr_en = 1'b1;
					wr_rd = inst[15:11];
					case (inst[5:0])
						fn_add: wr_val = a + b;
						fn_sub: wr_val = a - b;
						fn_and: wr_val = a & b;
						fn_or: wr_val = a | b;
						fn_slt: wr_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr_en = 1'b0;
					endcase
				end
				op_addi: begin
					wr_en = 1'b1;
					wr_val = a + imm;
				end
				op_lw: begin
					wr_en = 1'b1;
					wr_val = dmem[addr[9:2]];
				end
				op_sw: dmem[addr[9:2]] = b;
				op_beq, op_bne: begin
					if ((op == op_beq) == (a == b)) begin
						pc = pc + imm;
						expected_cycles += 2;
					end
				end
				op_j: begin
					pc = {pc[31:26], inst[25:0]};
					expected_cycles++;
				end
				op_hlt: done = 1'b1;
				default: ;
			endcase
			if (wr_en && wr_rd != 5'd0) begin
				regs[wr_rd] = wr_val;
				exp_rd.push_back(wr_rd);
				exp_data.push_back(wr_val);
			end
		end
		if (!done) begin
			$display("Reference model found no hlt within 500 instructions");
			error_count++;
		end
	endtask

	task automatic apply_reset();
		@(posedge input_clk);
		#1 rst = 1'b1;
		repeat (reset_cycles) @(posedge input_clk);
		#1;
		check_value("PC", PC, 32'd0);
		check_value("wb_valid", 32'(wb_valid), 32'd0);
		check_value("halted", 32'(halted), 32'd0);
		check_value("cycles_consumed", cycles_consumed, 32'd0);
		rst = 1'b0;
	endtask

	task automatic run_program(input string name, input logic [31:0] never_written);
		int errors_before;
		int edges;
		logic [31:0] pc_at_halt;
		logic [31:0] cycles_at_halt;
		errors_before = error_count;
		fill_imem();
		model_program();
		written_mask = '0;
		monitor_on = 1'b1;
		apply_reset();
		edges = 0;
		while (!halted && edges < test_budget) begin
			@(posedge input_clk);
			#1;
			edges++;
		end
		if (!halted) begin
			$display("%s: halted never went high within %0d cycles", name, test_budget);
			error_count++;
		end else begin
			check_value("halt edges", edges, expected_cycles);
			check_value("cycles_consumed", cycles_consumed, expected_cycles);
			pc_at_halt = PC;
			cycles_at_halt = cycles_consumed;
			repeat (freeze_cycles) @(posedge input_clk);
			#1;
			check_value("PC", PC, pc_at_halt);
			check_value("cycles_consumed", cycles_consumed, cycles_at_halt);
		end
		if (exp_rd.size() != 0) begin
			$display("%s: %0d expected write-backs never appeared", name, exp_rd.size());
			error_count++;
		end
		check_value("shadow writes", written_mask & never_written, 32'd0);
		monitor_on = 1'b0;
		if (error_count == errors_before) begin
			$display("%s: passed", name);
			tests_passed++;
		end else begin
			$display("%s: FAILED with %0d errors", name, error_count - errors_before);
			tests_failed++;
		end
	endtask

	initial begin
		input_clk = 1'b0;
		rst = 1'b1;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycle_count = 0;
		monitor_on = 1'b0;
		written_mask = '0;
		rng_state = 32'd21;
		fill_imem();
		alu_chain_program();
		run_program("alu chain", 32'h0);
		load_store_program();
		run_program("load and store", 32'h0);
		branch_program();
		run_program("branches", 32'h0000_1c00);
		halt_timing_program();
		run_program("halt timing", 32'h0);
		jump_program();
		run_program("jump", 32'h0000_0004);
		random_program();
		run_program("random program", 32'h0);
		$display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
			tests_passed, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+test
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/forward_unit.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/pl_cpu.sv
test/tb_pl_cpu.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_pl_cpu -f flist.f

output=$(./obj_dir/Vtb_pl_cpu)
printf '%s\n' "$output"

if grep -q "Simulation completed successfully" <<< "$output"; then
	exit 0
fi
exit 1
